/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // character format
    localparam int DATA_BITS = 8; // bits per character, lsb first on the line

    // clocking
    localparam logic [31:0] CLK_RATE_HZ      = 32'd200_000_000; // module clock
    localparam logic [31:0] BAUD_RATE        = 32'd115_200; // serial rate
    localparam logic [31:0] CLKS_PER_BIT_DEF = CLK_RATE_HZ / BAUD_RATE; // 1736 at 200 MHz

    // interrupt timing
    localparam logic [31:0] IRQ_PERIOD_DEF  = 32'd1_000_000; // 5 ms at 200 MHz
    localparam logic [31:0] IRQ_PULSE_WIDTH = 32'd2; // 10 ns high time

    // one character
    typedef logic [DATA_BITS-1:0] uart_data_t;

    // single-cycle character event between rx and tx
    typedef struct packed {
        logic       valid; // high for one clock per character
        uart_data_t data; // character payload
    } uart_byte_t;

    // serial frame states, shared by rx and tx
    typedef enum logic [1:0] {
        IDLE  = 2'd0, // line idle (high)
        START = 2'd1, // start bit
        DATA  = 2'd2, // data bits
        STOP  = 2'd3  // stop bit
    } uart_state_e;

    // bit timing and period counters
    typedef logic [31:0] cnt_t;

endpackage

`default_nettype wire

/* uart/uart_rx.sv */
`default_nettype none

module uart_rx #(
    parameter uart_pkg::cnt_t CLKS_PER_BIT = uart_pkg::CLKS_PER_BIT_DEF
) (
    input  logic                 clk_200_i   , // 200 MHz clock
    input  logic                 rst_n_i     , // async reset, active low
    input  logic                 rx_i        , // serial line, async to clk
    output uart_pkg::uart_byte_t rx_byte_o   , // received character event
    output logic                 frame_err_o   // stop bit read low
);

    logic                                   rx_meta_q;   // first sync stage
    logic                                   rx_sync_q;   // second sync stage
    logic                                   rx_prev_q;   // for edge detect
    logic                                   start_fall;  // falling edge on the line
    uart_pkg::uart_state_e                  state_q;
    uart_pkg::cnt_t                         cnt_q;       // clocks within the bit
    logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_idx_q;   // data bit number
    logic                                   half_end;    // middle of the start bit
    logic                                   bit_end;     // middle of data and stop bits
    logic                                   valid_q;
    logic                                   frame_err_q;
    uart_pkg::uart_data_t                   shift_q;     // lsb arrives first

    assign start_fall = rx_prev_q & ~rx_sync_q;
    assign half_end   = (cnt_q == (CLKS_PER_BIT >> 1) - 32'd1);
    assign bit_end    = (cnt_q == CLKS_PER_BIT - 32'd1);

    always_ff @(posedge clk_200_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta_q   <= 1'b1; // line idles high
            rx_sync_q   <= 1'b1;
            rx_prev_q   <= 1'b1;
            state_q     <= uart_pkg::IDLE;
            cnt_q       <= '0;
            bit_idx_q   <= '0;
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            rx_meta_q   <= rx_i;
            rx_sync_q   <= rx_meta_q;
            rx_prev_q   <= rx_sync_q;
            valid_q     <= 1'b0; // single-cycle events
            frame_err_q <= 1'b0;
            case (state_q)
                uart_pkg::IDLE: begin
                    cnt_q <= '0;
                    if (start_fall) begin
                        state_q <= uart_pkg::START;
                    end
                end
                uart_pkg::START: begin
                    if (half_end) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        if (rx_sync_q) begin
                            state_q <= uart_pkg::IDLE; // glitch, not a start bit
                        end else begin
                            state_q <= uart_pkg::DATA;
                        end
                    end else begin
                        cnt_q <= cnt_q + 32'd1;
                    end
                end
                uart_pkg::DATA: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        if (int'(bit_idx_q) == uart_pkg::DATA_BITS - 1) begin
                            state_q <= uart_pkg::STOP;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 32'd1;
                    end
                end
                uart_pkg::STOP: begin
                    if (bit_end) begin
                        cnt_q       <= '0;
                        state_q     <= uart_pkg::IDLE;
                        valid_q     <= rx_sync_q; // good stop bit
                        frame_err_q <= ~rx_sync_q; // byte dropped
                    end else begin
                        cnt_q <= cnt_q + 32'd1;
                    end
                end
                default: state_q <= uart_pkg::IDLE;
            endcase
        end
    end

    // data bits shift in from the top
    always_ff @(posedge clk_200_i) begin
        if (state_q == uart_pkg::DATA && bit_end) begin
            shift_q <= {rx_sync_q, shift_q[uart_pkg::DATA_BITS-1:1]};
        end
    end

    assign rx_byte_o   = '{valid: valid_q, data: shift_q};
    assign frame_err_o = frame_err_q;

    // a frame ends either accepted or rejected, never both
    a_valid_xor_err: assert property (@(posedge clk_200_i) disable iff (!rst_n_i)
        !(rx_byte_o.valid && frame_err_o))
        else $error("uart_rx: valid and frame error in the same cycle");

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`default_nettype none

module uart_tx #(
    parameter uart_pkg::cnt_t CLKS_PER_BIT = uart_pkg::CLKS_PER_BIT_DEF
) (
    input  logic                 clk_200_i , // 200 MHz clock
    input  logic                 rst_n_i   , // async reset, active low
    input  uart_pkg::uart_byte_t tx_byte_i , // character to send, no back-pressure
    output logic                 tx_o        // serial line
);

    uart_pkg::uart_state_e                  state_q;
    uart_pkg::cnt_t                         cnt_q;       // clocks within the bit
    logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_idx_q;   // data bit number
    logic                                   tx_q;        // registered line driver
    logic                                   bit_end;     // last clock of a bit
    logic                                   frame_end;   // last clock of the stop bit
    logic                                   take_in;     // incoming byte starts now
    logic                                   take_hold;   // held byte starts now
    logic                                   hold_full_q;
    uart_pkg::uart_data_t                   hold_q;      // pending character
    uart_pkg::uart_data_t                   shift_q;     // bit 0 is next on the line

    assign bit_end   = (cnt_q == CLKS_PER_BIT - 32'd1);
    assign frame_end = (state_q == uart_pkg::STOP) && bit_end;

    // the held byte always goes first
    assign take_hold = hold_full_q && frame_end;
    assign take_in   = tx_byte_i.valid && !hold_full_q &&
                       ((state_q == uart_pkg::IDLE) || frame_end);

    always_ff @(posedge clk_200_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= uart_pkg::IDLE;
            cnt_q       <= '0;
            bit_idx_q   <= '0;
            tx_q        <= 1'b1; // idle line
            hold_full_q <= 1'b0;
        end else begin
            case (state_q)
                uart_pkg::IDLE: begin
                    cnt_q <= '0;
                    if (take_in) begin
                        state_q <= uart_pkg::START;
                        tx_q    <= 1'b0; // start bit
                    end
                end
                uart_pkg::START: begin
                    if (bit_end) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        state_q   <= uart_pkg::DATA;
                        tx_q      <= shift_q[0];
                    end else begin
                        cnt_q <= cnt_q + 32'd1;
                    end
                end
                uart_pkg::DATA: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        if (int'(bit_idx_q) == uart_pkg::DATA_BITS - 1) begin
                            state_q <= uart_pkg::STOP;
                            tx_q    <= 1'b1; // stop bit
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_q      <= shift_q[1]; // shift_q moves down this clock
                        end
                    end else begin
                        cnt_q <= cnt_q + 32'd1;
                    end
                end
                uart_pkg::STOP: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        if (take_hold || take_in) begin
                            state_q <= uart_pkg::START; // back-to-back frame
                            tx_q    <= 1'b0;
                        end else begin
                            state_q <= uart_pkg::IDLE;
                        end
                    end else begin
                        cnt_q <= cnt_q + 32'd1;
                    end
                end
                default: state_q <= uart_pkg::IDLE;
            endcase

            if (tx_byte_i.valid && !take_in) begin
                hold_full_q <= 1'b1;
            end else if (take_hold) begin
                hold_full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_200_i) begin
        if (take_hold) begin
            shift_q <= hold_q;
        end else if (take_in) begin
            shift_q <= tx_byte_i.data;
        end else if (state_q == uart_pkg::DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
        if (tx_byte_i.valid && !take_in) begin
            hold_q <= tx_byte_i.data; // busy, park it
        end
    end

    assign tx_o = tx_q;

    a_idle_high: assert property (@(posedge clk_200_i) disable iff (!rst_n_i)
        (state_q == uart_pkg::IDLE) |-> tx_o)
        else $error("uart_tx: line low while idle");

    // sender must keep characters at least one frame apart
    a_no_overflow: assert property (@(posedge clk_200_i) disable iff (!rst_n_i)
        !(tx_byte_i.valid && hold_full_q))
        else $error("uart_tx: holding register overflow");

endmodule

`default_nettype wire

/* hdl/irq_pulse_gen.sv */
`default_nettype none

module irq_pulse_gen #(
    parameter uart_pkg::cnt_t IRQ_PERIOD = uart_pkg::IRQ_PERIOD_DEF
) (
    input  logic clk_200_i , // 200 MHz clock
    input  logic rst_n_i   , // async reset, active low
    output logic irq_o       // periodic pulse
);

    uart_pkg::cnt_t cnt_q;     // position within the period
    uart_pkg::cnt_t cnt_nxt;
    logic           irq_q;

    // wrap at the end of the period
    assign cnt_nxt = (cnt_q == IRQ_PERIOD - 32'd1) ? '0 : cnt_q + 32'd1;

    always_ff @(posedge clk_200_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            irq_q <= 1'b0;
        end else begin
            cnt_q <= cnt_nxt;
            irq_q <= (cnt_nxt >= IRQ_PERIOD - uart_pkg::IRQ_PULSE_WIDTH); // tail of period
        end
    end

    assign irq_o = irq_q;

    // pulse drops after exactly the configured width
    a_pulse_width: assert property (@(posedge clk_200_i) disable iff (!rst_n_i)
        $rose(irq_o) |-> ##(uart_pkg::IRQ_PULSE_WIDTH) !irq_o)
        else $error("irq_pulse_gen: pulse longer than IRQ_PULSE_WIDTH");

endmodule

`default_nettype wire

/* hdl/pl_test_top.sv */
`default_nettype none

module pl_test_top #(
    parameter uart_pkg::cnt_t CLKS_PER_BIT = uart_pkg::CLKS_PER_BIT_DEF, // serial bit time
    parameter uart_pkg::cnt_t IRQ_PERIOD   = uart_pkg::IRQ_PERIOD_DEF    // interrupt period
) (
    input  logic clk_200_i   , // 200 MHz clock
    input  logic rst_n_i     , // async reset, active low
    input  logic uart_rx_i   , // serial in
    output logic uart_tx_o   , // serial echo out
    output logic irq_o       , // periodic interrupt
    output logic frame_err_o   // bad stop bit seen
);

    uart_pkg::uart_byte_t echo_byte; // rx straight into tx

    uart_rx #(
        .CLKS_PER_BIT               ( CLKS_PER_BIT              )
    ) u_uart_rx (
        .clk_200_i                  ( clk_200_i                 ),
        .rst_n_i                    ( rst_n_i                   ),
        .rx_i                       ( uart_rx_i                 ), // from host
        .rx_byte_o                  ( echo_byte                 ),
        .frame_err_o                ( frame_err_o               )
    );

    uart_tx #(
        .CLKS_PER_BIT               ( CLKS_PER_BIT              )
    ) u_uart_tx (
        .clk_200_i                  ( clk_200_i                 ),
        .rst_n_i                    ( rst_n_i                   ),
        .tx_byte_i                  ( echo_byte                 ), // echo loop
        .tx_o                       ( uart_tx_o                 )  // back to host
    );

    irq_pulse_gen #(
        .IRQ_PERIOD                 ( IRQ_PERIOD                )
    ) u_irq_pulse_gen (
        .clk_200_i                  ( clk_200_i                 ),
        .rst_n_i                    ( rst_n_i                   ),
        .irq_o                      ( irq_o                     )
    );

endmodule

`default_nettype wire

/* verif/tb_pl_test_top.sv */
`default_nettype none

module tb_pl_test_top;

    localparam int CLKS_PER_BIT = 16; // short bit time for simulation
    localparam int IRQ_PERIOD   = 200;
    localparam int PULSE_WIDTH  = int'(uart_pkg::IRQ_PULSE_WIDTH);
    localparam int TABLE_LEN    = 12;
    localparam int TIMEOUT      = 2 * (TABLE_LEN * 12 * CLKS_PER_BIT * 10 + 5 * IRQ_PERIOD * 10);

    // one row of the stimulus table
    typedef struct packed {
        logic [7:0] data;
        logic       stop; // stop bit level on the line
        logic [7:0] gap;  // idle bit times after the frame
        logic       echo; // frame should come back on uart_tx_o
    } stim_t;

    logic        clk_200 = 1'b0;
    logic        rst_n;
    logic        uart_rx;
    logic        uart_tx;
    logic        irq;
    logic        frame_err;

    stim_t       stim_tbl [TABLE_LEN];
    logic [7:0]  exp_q [$];  // bytes that should be echoed
    logic [7:0]  echo_q [$]; // bytes decoded from uart_tx_o
    logic [31:0] rng_q;
    logic        tx_prev = 1'b1;
    int          value_errs = 0;
    int          other_errs = 0;
    int          ferr_seen = 0;
    int          ferr_exp = 0;
    int          irq_rises = 0;

    pl_test_top #(
        .CLKS_PER_BIT               ( CLKS_PER_BIT              ),
        .IRQ_PERIOD                 ( IRQ_PERIOD                )
    ) u_pl_test_top (
        .clk_200_i                  ( clk_200                   ),
        .rst_n_i                    ( rst_n                     ),
        .uart_rx_i                  ( uart_rx                   ),
        .uart_tx_o                  ( uart_tx                   ),
        .irq_o                      ( irq                       ),
        .frame_err_o                ( frame_err                 )
    );

    always #5 clk_200 = ~clk_200;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("ERR %0t %s expected %0h got %0h", $time, name, exp_v, got_v);
        value_errs++;
    endtask

    task automatic build_table;
        int i;
        rng_q = 32'd59274;
        stim_tbl[0] = '{data: 8'h00, stop: 1'b1, gap: 8'd20, echo: 1'b1}; // lone frame
        stim_tbl[1] = '{data: 8'hFF, stop: 1'b1, gap: 8'd0, echo: 1'b1};  // back to back
        stim_tbl[2] = '{data: 8'hA5, stop: 1'b1, gap: 8'd0, echo: 1'b1};
        stim_tbl[3] = '{data: 8'h3C, stop: 1'b1, gap: 8'd4, echo: 1'b1};
        stim_tbl[4] = '{data: 8'h5A, stop: 1'b0, gap: 8'd4, echo: 1'b0};  // bad stop bit
        stim_tbl[5] = '{data: 8'hC3, stop: 1'b1, gap: 8'd2, echo: 1'b1};  // recovers
        for (i = 6; i < TABLE_LEN; i++) begin
            rng_q = xorshift32(rng_q);
            stim_tbl[i] = '{data: rng_q[7:0], stop: 1'b1, gap: 8'd0, echo: 1'b1};
        end
        stim_tbl[TABLE_LEN-1].gap = 8'd2;
    endtask

    // hold one level on the line for a whole bit time
    task automatic drive_bit(input logic b);
        @(posedge clk_200);
        uart_rx <= b;
        repeat (CLKS_PER_BIT - 1) @(posedge clk_200);
    endtask

    task automatic send_frame(input stim_t e);
        int i;
        drive_bit(1'b0); // start bit
        for (i = 0; i < 8; i++) begin
            drive_bit(e.data[i]); // lsb first
        end
        drive_bit(e.stop);
        for (i = 0; i < int'(e.gap); i++) begin
            drive_bit(1'b1);
        end
    endtask

    task automatic check_reset_state;
        int i;
        for (i = 0; i < 4; i++) begin
            @(negedge clk_200);
            if (uart_tx !== 1'b1) begin
                report_mismatch("uart_tx_o", 32'd1, 32'(uart_tx));
            end
            if (irq !== 1'b0) begin
                report_mismatch("irq_o", 32'd0, 32'(irq));
            end
            if (frame_err !== 1'b0) begin
                report_mismatch("frame_err_o", 32'd0, 32'(frame_err));
            end
        end
    endtask

    // serial monitor sampling uart_tx_o at mid-bit on falling clock edges
    always begin : tx_monitor
        logic [7:0] b;
        int         i;
        @(negedge clk_200);
        if (rst_n === 1'b1 && tx_prev === 1'b1 && uart_tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk_200);
            if (uart_tx !== 1'b0) begin
                report_mismatch("uart_tx_o start bit", 32'd0, 32'(uart_tx));
            end
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk_200);
                b[i] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk_200);
            if (uart_tx !== 1'b1) begin
                report_mismatch("uart_tx_o stop bit", 32'd1, 32'(uart_tx));
            end
            echo_q.push_back(b);
        end
        tx_prev = uart_tx;
    end

    always @(negedge clk_200) begin
        if (rst_n === 1'b1 && frame_err === 1'b1) begin
            ferr_seen++; // one count per high cycle
        end
    end

    // interrupt timing with cycle 0 as the first clock after reset release
    initial begin : irq_checker
        int cyc;
        int next_rise;
        int rise_cyc;
        logic irq_prev;
        cyc       = 0;
        next_rise = IRQ_PERIOD - PULSE_WIDTH;
        rise_cyc  = 0;
        irq_prev  = 1'b0;
        @(posedge rst_n);
        forever begin
            @(negedge clk_200);
            if (irq === 1'b1 && irq_prev === 1'b0) begin
                if (cyc != next_rise) begin
                    report_mismatch("irq_o rise cycle", 32'(next_rise), 32'(cyc));
                end
                irq_rises++;
                rise_cyc  = cyc;
                next_rise = cyc + IRQ_PERIOD;
            end else if (irq !== 1'b1 && cyc == next_rise) begin
                report_mismatch("irq_o", 32'd1, 32'(irq));
                next_rise = next_rise + IRQ_PERIOD;
            end
            if (irq === 1'b0 && irq_prev === 1'b1) begin
                if (cyc - rise_cyc != PULSE_WIDTH) begin
                    report_mismatch("irq_o width", 32'(PULSE_WIDTH), 32'(cyc - rise_cyc));
                end
            end
            irq_prev = irq;
            cyc      = cyc + 1;
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        other_errs++;
        $display("timeout: echoes or interrupt pulses did not arrive in time");
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main_seq
        int         i;
        int         n;
        logic [7:0] exp_b;
        logic [7:0] got_b;
        rst_n   = 1'b0;
        uart_rx = 1'b1;
        build_table();
        repeat (4) @(posedge clk_200);
        rst_n <= 1'b1;
        check_reset_state();

        drive_bit(1'b1);
        drive_bit(1'b1);
        for (i = 0; i < TABLE_LEN; i++) begin
            if (stim_tbl[i].echo) begin
                exp_q.push_back(stim_tbl[i].data);
            end
            if (!stim_tbl[i].stop) begin
                ferr_exp++;
            end
            send_frame(stim_tbl[i]);
        end

        while (echo_q.size() < exp_q.size()) begin
            @(negedge clk_200);
        end
        repeat (12 * CLKS_PER_BIT) @(negedge clk_200); // room for a stray echo
        while (irq_rises < 3) begin
            @(negedge clk_200);
        end

        if (echo_q.size() != exp_q.size()) begin
            report_mismatch("echo count", 32'(exp_q.size()), 32'(echo_q.size()));
        end
        n = (echo_q.size() < exp_q.size()) ? echo_q.size() : exp_q.size();
        for (i = 0; i < n; i++) begin
            exp_b = exp_q.pop_front();
            got_b = echo_q.pop_front();
            if (got_b !== exp_b) begin
                report_mismatch("uart_tx_o data", 32'(exp_b), 32'(got_b));
            end
        end
        if (ferr_seen != ferr_exp) begin
            report_mismatch("frame_err_o pulses", 32'(ferr_exp), 32'(ferr_seen));
        end

        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
common/uart_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/irq_pulse_gen.sv
hdl/pl_test_top.sv
verif/tb_pl_test_top.sv

/* run.sh */
#!/bin/sh
# Build and run the echo-loop testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_pl_test_top

# the log decides pass or fail, so a nonzero simulator exit is not fatal here
./obj_dir/Vtb_pl_test_top > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Finished with no errors" "$LOG"; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: simulation failed, see $LOG"
    exit 1
fi
